// File: spart_pkg.sv
package spart_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Serial timing
	////////////////////////////////////////////////////////////////////////////

	// Clocks per oversample tick
	localparam logic [15:0] BAUD_DIV = 16'd16;

	// Oversample ticks per bit time
	localparam int unsigned OVERSAMPLE = 16;

	localparam int unsigned BYTE_W = 8;

	// Start bit, data bits, stop bit
	localparam int unsigned FRAME_W = BYTE_W + 2;

	// Counter widths and compare points
	localparam int unsigned OS_W = $clog2(OVERSAMPLE);
	localparam int unsigned BIT_W = $clog2(BYTE_W);
	localparam int unsigned FRAME_CNT_W = $clog2(FRAME_W);
	localparam logic [OS_W-1:0] OS_MID = OS_W'(OVERSAMPLE / 2 - 1);
	localparam logic [OS_W-1:0] OS_LAST = OS_W'(OVERSAMPLE - 1);

	////////////////////////////////////////////////////////////////////////////
	// Command and LED types
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [7:0] {
		OP_SET    = 8'h01,
		OP_TOGGLE = 8'h02,
		OP_READ   = 8'h04,
		OP_CLEAR  = 8'h05
	} cmd_op_e;

	typedef enum logic [2:0] {
		LED_NONE = 3'd0,
		LED_SET  = 3'd1,
		LED_XOR  = 3'd2,
		LED_CLR  = 3'd3
	} led_kind_e;

	// One received byte, data only meaningful with valid
	typedef struct packed {
		logic              valid;
		logic              frame_err;
		logic [BYTE_W-1:0] data;
	} rx_byte_t;

	typedef struct packed {
		led_kind_e         kind;
		logic [BYTE_W-1:0] data;
	} led_op_t;

endpackage

// File: spart_baud_gen.sv
`timescale 1ns/1ps

module spart_baud_gen import spart_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	// Down-counter, one tick per wrap
	logic [15:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= BAUD_DIV - 16'd1;
		end else if (cnt == 16'd0) begin
			cnt <= BAUD_DIV - 16'd1;
		end else begin
			cnt <= cnt - 16'd1;
		end
	end

	// Registered so the strobe is glitch free for both directions
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick <= 1'b0;
		end else begin
			tick <= (cnt == 16'd0);
		end
	end

endmodule

// File: spart_rx.sv
`timescale 1ns/1ps

module spart_rx import spart_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     tick,
	input  logic     rxd,
	output rx_byte_t rx
);

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		RX_DONE
	} rx_state_e;

	rx_state_e         state;
	logic              rx_meta;
	logic              rx_sync;
	logic              rx_prev;
	logic              fall;
	logic              data_smp;
	logic [OS_W-1:0]   os_cnt;
	logic [BIT_W-1:0]  bit_cnt;
	logic [BYTE_W-1:0] shift_q;
	logic              stop_q;
	logic              valid_q;
	logic              ferr_q;

	////////////////////////////////////////////////////////////////////////////
	// Input synchronizer and start edge
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign fall = rx_prev & ~rx_sync;

	// Center of a data bit
	assign data_smp = (state == RX_DATA) && tick && (os_cnt == OS_LAST);

	////////////////////////////////////////////////////////////////////////////
	// Bit timing FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= RX_IDLE;
			os_cnt  <= '0;
			bit_cnt <= '0;
			stop_q  <= 1'b1;
			valid_q <= 1'b0;
			ferr_q  <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (fall) begin
						os_cnt <= '0;
						state  <= RX_START;
					end
				end
				RX_START: begin
					if (tick) begin
						if (os_cnt == OS_MID) begin
							os_cnt  <= '0;
							bit_cnt <= '0;
							// A high line at mid start bit was a glitch
							state   <= rx_sync ? RX_IDLE : RX_DATA;
						end else begin
							os_cnt <= os_cnt + 1'b1;
						end
					end
				end
				RX_DATA: begin
					if (tick) begin
						os_cnt <= os_cnt + 1'b1;
						if (os_cnt == OS_LAST) begin
							os_cnt  <= '0;
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == BIT_W'(BYTE_W - 1)) begin
								state <= RX_STOP;
							end
						end
					end
				end
				RX_STOP: begin
					if (tick) begin
						os_cnt <= os_cnt + 1'b1;
						if (os_cnt == OS_LAST) begin
							stop_q <= rx_sync;
							state  <= RX_DONE;
						end
					end
				end
				RX_DONE: begin
					valid_q <= 1'b1;
					ferr_q  <= ~stop_q;
					state   <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk) begin
		if (data_smp) begin
			shift_q <= {rx_sync, shift_q[BYTE_W-1:1]};
		end
	end

	assign rx = '{valid: valid_q, frame_err: ferr_q, data: shift_q};

endmodule

// File: spart_tx.sv
`timescale 1ns/1ps

module spart_tx import spart_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              tick,
	input  logic              trmt,
	input  logic [BYTE_W-1:0] tx_data,
	output logic              tbr,
	output logic              txd
);

	logic                   busy;
	logic                   started;
	logic                   load;
	logic                   shift;
	logic [OS_W-1:0]        os_cnt;
	logic [FRAME_CNT_W-1:0] bit_cnt;
	logic [FRAME_W-1:0]     frame_q;

	assign load  = trmt & ~busy;
	assign shift = busy & started & tick & (os_cnt == OS_LAST);

	////////////////////////////////////////////////////////////////////////////
	// Frame sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			started <= 1'b0;
			os_cnt  <= '0;
			bit_cnt <= '0;
		end else if (load) begin
			busy    <= 1'b1;
			started <= 1'b0;
			os_cnt  <= '0;
			bit_cnt <= '0;
		end else if (busy && tick) begin
			if (!started) begin
				// First tick after the strobe opens the start bit
				started <= 1'b1;
			end else begin
				os_cnt <= os_cnt + 1'b1;
				if (os_cnt == OS_LAST) begin
					os_cnt  <= '0;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == FRAME_CNT_W'(FRAME_W - 1)) begin
						busy    <= 1'b0;
						started <= 1'b0;
					end
				end
			end
		end
	end

	// Stop, data, start with the start bit at bit 0
	always_ff @(posedge clk) begin
		if (load) begin
			frame_q <= {1'b1, tx_data, 1'b0};
		end else if (shift) begin
			frame_q <= {1'b1, frame_q[FRAME_W-1:1]};
		end
	end

	assign tbr = ~busy;
	assign txd = started ? frame_q[0] : 1'b1;

endmodule

// File: cmd_fsm.sv
`timescale 1ns/1ps

module cmd_fsm import spart_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  rx_byte_t rx,
	input  logic     spu_int,
	input  logic     tbr,
	output led_op_t  led_op,
	output logic     trmt
);

	typedef enum logic [1:0] {
		IDLE,
		STREAM_SET,
		STREAM_XOR,
		READ_WAIT
	} state_e;

	state_e state;
	logic   byte_ok;
	logic   is_term;

	// Bytes with a bad stop bit never reach the decoder
	assign byte_ok = rx.valid & ~rx.frame_err;
	assign is_term = (rx.data == '0);

	////////////////////////////////////////////////////////////////////////////
	// Command decoder
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= IDLE;
			led_op <= '{kind: LED_NONE, data: '0};
			trmt   <= 1'b0;
		end else begin
			led_op.kind <= LED_NONE;
			trmt        <= 1'b0;
			if (spu_int) begin
				// Abort everything while the processing unit holds the line
				state <= IDLE;
			end else begin
				case (state)
					IDLE: begin
						if (byte_ok) begin
							case (cmd_op_e'(rx.data))
								OP_SET:    state <= STREAM_SET;
								OP_TOGGLE: state <= STREAM_XOR;
								OP_CLEAR:  led_op.kind <= LED_CLR;
								OP_READ: begin
									// A strobe still in flight counts as busy
									if (tbr && !trmt) begin
										trmt <= 1'b1;
									end else begin
										state <= READ_WAIT;
									end
								end
								default: state <= IDLE;
							endcase
						end
					end
					STREAM_SET: begin
						if (byte_ok) begin
							if (is_term) begin
								state <= IDLE;
							end else begin
								led_op <= '{kind: LED_SET, data: rx.data};
							end
						end
					end
					STREAM_XOR: begin
						if (byte_ok) begin
							if (is_term) begin
								state <= IDLE;
							end else begin
								led_op <= '{kind: LED_XOR, data: rx.data};
							end
						end
					end
					// One reply held until the transmitter frees up
					READ_WAIT: begin
						if (tbr) begin
							trmt  <= 1'b1;
							state <= IDLE;
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

endmodule

// File: led_bank.sv
`timescale 1ns/1ps

module led_bank import spart_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  led_op_t           led_op,
	output logic [BYTE_W-1:0] leds
);

	////////////////////////////////////////////////////////////////////////////
	// LED register
	////////////////////////////////////////////////////////////////////////////

	// Value feeds the pins and the READ reply
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			leds <= '0;
		end else begin
			case (led_op.kind)
				LED_SET: begin
					leds <= led_op.data;
				end
				LED_XOR: begin
					leds <= leds ^ led_op.data;
				end
				LED_CLR: begin
					leds <= '0;
				end
				// LED_NONE and unused codes hold the value
				default: begin
					leds <= leds;
				end
			endcase
		end
	end

endmodule

// File: top_level.sv
`timescale 1ns/1ps

module top_level import spart_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic rxd,
	input  logic spu_int,
	output logic txd,
	output logic GPIO_LED_0,
	output logic GPIO_LED_1,
	output logic GPIO_LED_2,
	output logic GPIO_LED_3,
	output logic GPIO_LED_4,
	output logic GPIO_LED_5,
	output logic GPIO_LED_6,
	output logic GPIO_LED_7
);

	logic              tick;
	logic              trmt;
	logic              tbr;
	rx_byte_t          rx;
	led_op_t           led_op;
	logic [BYTE_W-1:0] leds;

	// One timer for both serial directions
	spart_baud_gen u_baud (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	spart_rx u_rx (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick),
		.rxd   (rxd),
		.rx    (rx)
	);

	spart_tx u_tx (
		.clk     (clk),
		.rst_n   (rst_n),
		.tick    (tick),
		.trmt    (trmt),
		.tx_data (leds),
		.tbr     (tbr),
		.txd     (txd)
	);

	cmd_fsm u_fsm (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx      (rx),
		.spu_int (spu_int),
		.tbr     (tbr),
		.led_op  (led_op),
		.trmt    (trmt)
	);

	led_bank u_leds (
		.clk    (clk),
		.rst_n  (rst_n),
		.led_op (led_op),
		.leds   (leds)
	);

	// Board pins
	assign GPIO_LED_0 = leds[0];
	assign GPIO_LED_1 = leds[1];
	assign GPIO_LED_2 = leds[2];
	assign GPIO_LED_3 = leds[3];
	assign GPIO_LED_4 = leds[4];
	assign GPIO_LED_5 = leds[5];
	assign GPIO_LED_6 = leds[6];
	assign GPIO_LED_7 = leds[7];

endmodule

// File: spart_assertions.sv
`timescale 1ns/1ps

module spart_assertions import spart_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input rx_byte_t rx,
	input led_op_t  led_op,
	input logic     trmt,
	input logic     tbr,
	input logic     txd
);

	// Failure count, read at the end of the run
	int unsigned fail_cnt = 0;

	////////////////////////////////////////////////////////////////////////////
	// FSM and transmitter rules
	////////////////////////////////////////////////////////////////////////////

	// Start strobe only toward an idle transmitter
	trmt_needs_tbr: assert property (@(posedge clk) disable iff (!rst_n)
		trmt |-> tbr)
	else begin
		$error("trmt pulsed while tbr was low");
		fail_cnt++;
	end

	// LED operations only right after a received byte
	op_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(rx.valid) |-> led_op.kind == LED_NONE)
	else begin
		$error("led_op kind not LED_NONE without a preceding rx valid");
		fail_cnt++;
	end

	// Idle line
	txd_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
		tbr |-> txd)
	else begin
		$error("txd low while tbr was high");
		fail_cnt++;
	end

endmodule

bind top_level spart_assertions u_sva (
	.clk    (clk),
	.rst_n  (rst_n),
	.rx     (rx),
	.led_op (led_op),
	.trmt   (trmt),
	.tbr    (tbr),
	.txd    (txd)
);

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top import spart_pkg::*; ();

	localparam int unsigned CLK_PERIOD = 10;
	localparam int unsigned BIT_CLK = int'(BAUD_DIV) * OVERSAMPLE;
	localparam int unsigned SEED = 74;

	// One row of the stimulus table
	typedef struct packed {
		logic [7:0] data;
		logic       bad_stop;
		logic       spu;
		logic [7:0] exp_leds;
		logic       reply;
		logic       idle;
	} entry_t;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       rxd;
	logic       spu_int;
	logic       txd;
	logic [7:0] leds;

	entry_t      table_q[$];
	logic [7:0]  reply_q[$];
	int unsigned check_cnt = 0;
	int unsigned err_cnt = 0;
	int unsigned replies_exp = 0;
	int unsigned replies_seen = 0;

	top_level uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.rxd        (rxd),
		.spu_int    (spu_int),
		.txd        (txd),
		.GPIO_LED_0 (leds[0]),
		.GPIO_LED_1 (leds[1]),
		.GPIO_LED_2 (leds[2]),
		.GPIO_LED_3 (leds[3]),
		.GPIO_LED_4 (leds[4]),
		.GPIO_LED_5 (leds[5]),
		.GPIO_LED_6 (leds[6]),
		.GPIO_LED_7 (leds[7])
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic add_entry(input logic [7:0] data, input logic bad_stop,
			input logic spu, input logic [7:0] exp_leds, input logic reply,
			input logic idle);
		table_q.push_back('{data, bad_stop, spu, exp_leds, reply, idle});
	endtask

	// Host side of the serial line, 8N1 with an optional low stop bit
	task automatic send_byte(input logic [7:0] data, input logic bad_stop);
		logic [9:0] frame;
		frame = {~bad_stop, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rxd <= frame[i];
			repeat (BIT_CLK - 1) @(posedge clk);
		end
		@(posedge clk);
		rxd <= 1'b1;
	endtask

	task automatic build_table();
		logic [7:0] model;
		logic [7:0] r;
		model = 8'h00;
		// Clear, then a SET stream
		add_entry(8'h05, 0, 0, 8'h00, 0, 1);
		add_entry(8'h01, 0, 0, 8'h00, 0, 1);
		add_entry(8'h96, 0, 0, 8'h96, 0, 1);
		add_entry(8'h97, 0, 0, 8'h97, 0, 1);
		add_entry(8'h98, 0, 0, 8'h98, 0, 1);
		add_entry(8'h00, 0, 0, 8'h98, 0, 1);
		model = 8'h98;
		// Second READ lands while the first reply is still on the line
		add_entry(8'h04, 0, 0, model, 1, 0);
		add_entry(8'h04, 0, 0, model, 1, 1);
		add_entry(8'h02, 0, 0, model, 0, 1);
		for (int i = 0; i < 4; i++) begin
			r = 8'($urandom_range(255, 1));
			model = model ^ r;
			add_entry(r, 0, 0, model, 0, 1);
		end
		add_entry(8'h00, 0, 0, model, 0, 1);
		add_entry(8'h04, 0, 0, model, 1, 1);
		// Unknown opcode and a CLEAR with a low stop bit
		add_entry(8'h33, 0, 0, model, 0, 1);
		add_entry(8'h05, 1, 0, model, 0, 1);
		add_entry(8'h01, 0, 0, model, 0, 1);
		r = 8'($urandom_range(255, 1));
		model = r;
		add_entry(r, 0, 0, model, 0, 1);
		// Terminator with a bad stop bit keeps the stream open
		add_entry(8'h00, 1, 0, model, 0, 1);
		r = 8'($urandom_range(255, 1));
		model = r;
		add_entry(r, 0, 0, model, 0, 1);
		add_entry(8'h00, 0, 0, model, 0, 1);
		// Abort held high, then the FSM must be back in IDLE
		add_entry(8'h01, 0, 1, model, 0, 1);
		add_entry(8'hA5, 0, 1, model, 0, 1);
		add_entry(8'hC3, 0, 0, model, 0, 1);
		add_entry(8'h01, 0, 0, model, 0, 1);
		add_entry(8'h81, 0, 0, 8'h81, 0, 1);
		add_entry(8'h00, 0, 0, 8'h81, 0, 1);
		add_entry(8'h04, 0, 0, 8'h81, 1, 1);
		add_entry(8'h05, 0, 0, 8'h00, 0, 1);
		add_entry(8'h04, 0, 0, 8'h00, 1, 1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reply decoder, samples txd at bit centers
	////////////////////////////////////////////////////////////////////////////

	initial begin : reply_decoder
		logic [7:0] got;
		forever begin
			@(negedge clk);
			if (rst_n === 1'b1 && txd === 1'b0) begin
				repeat (BIT_CLK / 2) @(negedge clk);
				if (txd !== 1'b0) begin
					err_cnt++;
					$display("Reply start bit was not low at its center, time %0t ns", $time);
				end
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CLK) @(negedge clk);
					got[i] = txd;
				end
				repeat (BIT_CLK) @(negedge clk);
				if (txd !== 1'b1) begin
					err_cnt++;
					$display("Reply stop bit was low, time %0t ns", $time);
				end
				replies_seen++;
				if (reply_q.size() == 0) begin
					err_cnt++;
					$display("A reply frame arrived with no READ outstanding");
				end else begin
					check_value("txd reply", got, reply_q.pop_front());
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		entry_t      e;
		longint      timeout_ns;
		int unsigned sva_fails;
		rst_n = 1'b0;
		rxd = 1'b1;
		spu_int = 1'b0;
		void'($urandom(SEED));
		build_table();
		timeout_ns = longint'(table_q.size()) * 12 * BIT_CLK * CLK_PERIOD
			+ 10 * CLK_PERIOD;
		fork
			begin
				#(timeout_ns);
				$display("Timeout after %0d ns, the table did not finish", timeout_ns);
				$display("Testbench failed");
				$finish;
			end
		join_none

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(negedge clk);
		check_value("txd", txd, 1);
		check_value("leds", leds, 0);

		foreach (table_q[i]) begin
			e = table_q[i];
			@(posedge clk);
			spu_int <= e.spu;
			if (e.reply) begin
				reply_q.push_back(e.exp_leds);
				replies_exp++;
			end
			send_byte(e.data, e.bad_stop);
			if (e.idle) begin
				repeat (BIT_CLK) @(posedge clk);
			end
			@(negedge clk);
			check_value("leds", leds, e.exp_leds);
		end

		// Let the last reply finish
		wait (reply_q.size() == 0);
		repeat (BIT_CLK) @(negedge clk);
		check_value("reply count", replies_seen, replies_exp);

		sva_fails = uut.u_sva.fail_cnt;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			check_cnt, err_cnt, sva_fails);
		if (err_cnt == 0 && sva_fails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: spart_led.f
spart_pkg.sv
spart_baud_gen.sv
spart_rx.sv
spart_tx.sv
cmd_fsm.sv
led_bank.sv
top_level.sv
spart_assertions.sv
tb_top.sv

// File: Bender.yml
package:
  name: spart_led

sources:
  - spart_pkg.sv
  - spart_baud_gen.sv
  - spart_rx.sv
  - spart_tx.sv
  - cmd_fsm.sv
  - led_bank.sv
  - top_level.sv
  - target: test
    files:
      - spart_assertions.sv
      - tb_top.sv
